// File: src.f
+incdir+hdl
hdl/video_pkg.sv
hdl/sprite_pkg.sv
hdl/video_timing.sv
hdl/sprite_register_bank.sv
hdl/print_controller.sv
hdl/sprite_line_counter.sv
hdl/pixel_memory.sv
hdl/sprite_print_top.sv
test/tb_sprite_print.sv

// File: run.sh
#!/bin/sh
# build the sprite print testbench with verilator and run it.
set -e
cd "$(dirname "$0")"
verilator --binary -j 0 --top-module tb_sprite_print -f src.f -o tb_sprite_print_sim
./obj_dir/tb_sprite_print_sim > sim.log
cat sim.log
if grep -q "Testbench failed" sim.log; then
	exit 1
fi

// File: test/tb_sprite_print.sv
//////////////////////////////////////////////////
// testbench for the sprite print engine. it loads
// images and sprites, checks pixels and timing.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "gpu_defines.svh"

module tb_sprite_print;

	localparam int NUM_TESTS      = 18;
	localparam int NUM_SPRITES    = 4;
	localparam int CAPTURE        = 30 * `SCREEN_X; // strobes kept for the first 30 lines.
	localparam int IMAGE_WORDS    = `SPRITE_SIZE * `SPRITE_SIZE;
	localparam int LINE_CYCLES    = `H_TOTAL * `PIXEL_CYCLES;
	localparam int STROBE_TIMEOUT = 200000; // longer than the blanking before line 0.
	localparam int FRAME_TIMEOUT  = 2 * `V_TOTAL * LINE_CYCLES;

	logic                     clk;
	logic                     reset;
	logic                     reg_write;
	logic [2:0]               reg_index;
	sprite_pkg::sprite_word_t reg_data;
	logic                     mem_write;
	sprite_pkg::mem_address_t mem_address;
	sprite_pkg::color_t       mem_data;
	logic                     hsync;
	logic                     vsync;
	sprite_pkg::color_t       color;
	logic                     color_valid;
	logic                     printing_screen;

	// pixel checks in raster order. a source of -1 means the background.
	int test_x   [NUM_TESTS] = '{0, 45, 10, 29, 20, 39, 600, 50, 25, 35, 619, 620,
	                             29, 20, 39, 600, 5, 639};
	int test_y   [NUM_TESTS] = '{0, 1, 2, 2, 5, 5, 8, 10, 12, 12, 15, 20, 21, 22, 24, 27, 29, 29};
	int test_src [NUM_TESTS] = '{-1, -1, 0, 0, 0, 1, 3, -1, 0, 1, 3, -1, 0, 1, 1, 3, -1, -1};

	// sprite 1 overlaps sprite 0, sprite 2 is hidden.
	int spr_x     [NUM_SPRITES] = '{10, 20, 40, 600};
	int spr_y     [NUM_SPRITES] = '{2, 5, 0, 8};
	int spr_image [NUM_SPRITES] = '{1, 2, 2, 0};
	bit spr_valid [NUM_SPRITES] = '{1'b1, 1'b1, 1'b0, 1'b1};

	sprite_pkg::color_t mem_copy [`MEM_DEPTH]; // what the host wrote.
	sprite_pkg::color_t captured [CAPTURE];    // colour of each strobe, by strobe number.
	int seed = 32'heb54;

	// monitor state, updated on the falling clock edge.
	int cycle = 0;
	bit prev_hsync = 1'b1;
	bit prev_vsync = 1'b1;
	bit in_frame = 1'b0;  // set once vsync has ended.
	int line_no = 0;
	int exp_strobes = 0;
	int line_strobes = 0;
	int line_high = 0;    // printing_screen cycles in this line.
	int last_strobe = 0;
	int last_hfall = 0;
	int strobe_total = 0;
	int vsync_falls = 0;
	int hfalls_in_frame = 0;
	int lines_checked = 0;
	int strobe_errors = 0;
	int spacing_errors = 0;
	int printing_errors = 0;
	int hsync_errors = 0;
	int vsync_errors = 0;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	bit timed_out = 1'b0;

	sprite_print_top i_sprite_print_top (
		.clk, .reset, .reg_write, .reg_index, .reg_data, .mem_write, .mem_address,
		.mem_data, .hsync, .vsync, .color, .color_valid, .printing_screen
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// lowest index valid sprite whose square holds the pixel, else -1.
	function automatic int covering_sprite(input int x, input int y);
		for (int s = 0; s < NUM_SPRITES; s++) begin
			if (spr_valid[2'(s)] && x >= spr_x[2'(s)] && x < spr_x[2'(s)] + `SPRITE_SIZE &&
			    y >= spr_y[2'(s)] && y < spr_y[2'(s)] + `SPRITE_SIZE) return s;
		end
		return -1;
	endfunction

	function automatic int expected_address(input int x, input int y, input int s);
		if (s < 0) return `BG_ADDRESS;
		return spr_image[2'(s)] * IMAGE_WORDS + (y - spr_y[2'(s)]) * `SPRITE_SIZE +
		       (x - spr_x[2'(s)]);
	endfunction

	task automatic write_memory(input int address, input sprite_pkg::color_t value);
		@(posedge clk);
		mem_write   <= 1'b1;
		mem_address <= 14'(address);
		mem_data    <= value;
		mem_copy[14'(address)] = value; // model copy for expected colours.
	endtask

	task automatic write_sprite(input int index);
		sprite_pkg::sprite_word_t word;
		word       = '0;
		word.valid = spr_valid[2'(index)];
		word.image = 5'(spr_image[2'(index)]);
		word.x     = 10'(spr_x[2'(index)]);
		word.y     = 10'(spr_y[2'(index)]);
		@(posedge clk);
		reg_write <= 1'b1;
		reg_index <= 3'(index);
		reg_data  <= word;
	endtask

	task automatic check_level(input string name, input logic got, input logic exp,
	                           inout int errors);
		if (got !== exp) begin
			$display("ERROR %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errors);
		tests_run++;
		error_count += errors;
		if (errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors);
		end
	endtask

	task automatic wait_for_strobe(input int target, output bit ok);
		int cycles;
		ok = 1'b0;
		for (cycles = 0; cycles < STROBE_TIMEOUT && !ok; cycles++) begin
			@(posedge clk);
			if (strobe_total > target) ok = 1'b1;
		end
	endtask

	task automatic wait_for_frame_end(output bit ok);
		int cycles;
		ok = 1'b0;
		for (cycles = 0; cycles < FRAME_TIMEOUT && !ok; cycles++) begin
			@(posedge clk);
			if (vsync_falls >= 2) ok = 1'b1; // a whole frame lies between two vsync falls.
		end
	endtask

	//////////////////////////////////////////////////
	// raster monitor
	//////////////////////////////////////////////////
	always @(negedge clk) begin
		if (reset) begin
			cycle++;
			if (in_frame && color_valid) begin
				if (line_strobes > 0 && cycle - last_strobe != `PIXEL_CYCLES) begin
					$display("ERROR color_valid spacing at strobe %0d: got %h expected %h",
					         strobe_total, cycle - last_strobe, `PIXEL_CYCLES);
					spacing_errors++;
				end
				if (strobe_total < CAPTURE) captured[15'(strobe_total)] = color;
				last_strobe = cycle;
				line_strobes++;
				strobe_total++; // strobe n is pixel (n mod 640, n div 640).
			end
			if (in_frame && printing_screen) line_high++;
			if (prev_hsync && !hsync) begin
				if (last_hfall > 0 && cycle - last_hfall != LINE_CYCLES) begin
					$display("ERROR hsync period: got %h expected %h", cycle - last_hfall,
					         LINE_CYCLES);
					hsync_errors++;
				end
				last_hfall = cycle;
				hfalls_in_frame++;
				if (in_frame) begin
					// the window up to this fall holds every strobe of line line_no.
					exp_strobes = (line_no < `SCREEN_Y) ? `SCREEN_X : 0;
					if (line_strobes != exp_strobes) begin
						$display("ERROR color_valid strobes in line %0d: got %h expected %h",
						         line_no, line_strobes, exp_strobes);
						strobe_errors++;
					end
					if (line_high != exp_strobes * `PIXEL_CYCLES) begin
						$display("ERROR printing_screen cycles in line %0d: got %h expected %h",
						         line_no, line_high, exp_strobes * `PIXEL_CYCLES);
						printing_errors++;
					end
					if (line_no < `SCREEN_Y) lines_checked++;
					line_no      = (line_no + 1) % `V_TOTAL;
					line_strobes = 0;
					line_high    = 0;
				end
			end
			if (prev_vsync && !vsync) begin
				if (vsync_falls > 0 && hfalls_in_frame != `V_TOTAL) begin
					$display("ERROR hsync falls per frame: got %h expected %h", hfalls_in_frame,
					         `V_TOTAL);
					vsync_errors++;
				end
				vsync_falls++;
				hfalls_in_frame = 0;
			end
			if (!prev_vsync && vsync && !in_frame) begin
				in_frame = 1'b1;       // strobe counting starts at the end of vsync.
				line_no  = `V_SYNC_END;
			end
			prev_hsync = hsync;
			prev_vsync = vsync;
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial begin
		int x;
		int y;
		int target;
		int errors;
		bit ok;
		sprite_pkg::color_t expected;
		reset       <= 1'b0;
		reg_write   <= 1'b0;
		reg_index   <= '0;
		reg_data    <= '0;
		mem_write   <= 1'b0;
		mem_address <= '0;
		mem_data    <= '0;
		repeat (10) @(posedge clk);
		errors = 0;
		check_level("hsync", hsync, 1'b1, errors); // outputs idle while in reset.
		check_level("vsync", vsync, 1'b1, errors);
		check_level("color_valid", color_valid, 1'b0, errors);
		check_level("printing_screen", printing_screen, 1'b0, errors);
		reset <= 1'b1;
		for (int a = 0; a < 3 * IMAGE_WORDS; a++) begin
			write_memory(a, sprite_pkg::color_t'(9'($random(seed)))); // images 0 to 2.
		end
		write_memory(`BG_ADDRESS, sprite_pkg::color_t'(9'($random(seed))));
		@(posedge clk);
		mem_write <= 1'b0;
		for (int s = 0; s < NUM_SPRITES; s++) write_sprite(s);
		@(posedge clk);
		reg_write <= 1'b0;
		if (printing_screen) begin
			$display("loading ran past vertical blanking into the visible area");
			errors++;
		end
		finish_test("reset and load", errors);

		for (int t = 0; t < NUM_TESTS; t++) begin
			x      = test_x[5'(t)];
			y      = test_y[5'(t)];
			target = y * `SCREEN_X + x;
			wait_for_strobe(target, ok);
			if (!ok) begin
				$display("timeout: the strobe for pixel (%0d,%0d) never came", x, y);
				timed_out = 1'b1;
				break;
			end
			errors = 0;
			if (covering_sprite(x, y) != test_src[5'(t)]) begin
				$display("table entry %0d names a source that breaks the priority rule", t);
				errors++;
			end
			expected = mem_copy[14'(expected_address(x, y, test_src[5'(t)]))];
			if (captured[15'(target)] !== expected) begin
				$display("ERROR color at (%0d,%0d): got %h expected %h", x, y,
				         captured[15'(target)], expected);
				errors++;
			end
			finish_test($sformatf("pixel %0d at (%0d,%0d)", t, x, y), errors);
		end

		if (!timed_out) begin
			wait_for_frame_end(ok);
			if (!ok) begin
				$display("timeout: the frame did not end with a second vsync");
				timed_out = 1'b1;
			end else begin
				if (lines_checked != `SCREEN_Y) begin
					$display("only %0d visible lines were seen in the frame", lines_checked);
					strobe_errors++;
				end
				finish_test("strobes per line", strobe_errors);
				finish_test("strobe spacing", spacing_errors);
				finish_test("printing_screen per line", printing_errors);
				finish_test("hsync once per line", hsync_errors);
				finish_test("vsync once per frame", vsync_errors);
			end
		end

		$display("tests run %0d, failed %0d, check errors %0d, visible lines %0d",
		         tests_run, tests_failed, error_count, lines_checked);
		if (!timed_out && tests_failed == 0 && error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: hdl/sprite_print_top.sv
//////////////////////////////////////////////////
// sprite print engine top: raster timing, sprite
// bank, print controller, line counter, memory.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "gpu_defines.svh"

module sprite_print_top (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             reg_write,
	input  logic [$clog2(`SPRITE_COUNT)-1:0] reg_index,
	input  sprite_pkg::sprite_word_t         reg_data,
	input  logic                             mem_write,
	input  sprite_pkg::mem_address_t         mem_address,
	input  sprite_pkg::color_t               mem_data,
	output logic                             hsync,
	output logic                             vsync,
	output sprite_pkg::color_t               color,
	output logic                             color_valid,
	output logic                             printing_screen
);

	// raster to controller.
	logic                     pixel_tick;
	logic                     active_area;
	video_pkg::coord_x_t      pixel_x;
	video_pkg::coord_y_t      pixel_y;
	// controller to bank and line counter.
	video_pkg::check_value_t  check_value;
	sprite_pkg::sprite_word_t data_reg;
	logic                     sprite_on;
	sprite_pkg::sprite_word_t sprite_datas;
	sprite_pkg::mem_address_t sprite_address;
	logic                     count_finished;
	// controller to memory.
	sprite_pkg::mem_address_t read_address;
	logic                     read_enable;
	sprite_pkg::color_t       read_data;

	video_timing i_video_timing (
		.clk, .reset, .pixel_tick, .active_area, .pixel_x, .pixel_y,
		.hsync, .vsync, .printing_screen
	);

	sprite_register_bank i_sprite_register_bank (
		.clk, .reset, .reg_write, .reg_index, .reg_data, .check_value, .data_reg
	);

	print_controller i_print_controller (
		.clk, .reset, .pixel_tick, .active_area, .pixel_x, .pixel_y, .data_reg,
		.sprite_address, .count_finished, .read_data, .check_value, .sprite_on,
		.sprite_datas, .read_address, .read_enable, .color, .color_valid
	);

	sprite_line_counter i_sprite_line_counter (
		.clk, .reset, .sprite_on, .sprite_datas, .check_value, .sprite_address,
		.count_finished
	);

	pixel_memory i_pixel_memory (
		.clk, .mem_write, .mem_address, .mem_data, .read_enable, .read_address,
		.read_data
	);

endmodule

// File: hdl/pixel_memory.sv
//////////////////////////////////////////////////
// pixel memory: colour words for all images and
// the background, host write and registered read.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "gpu_defines.svh"

module pixel_memory (
	input  logic                     clk,
	input  logic                     mem_write,
	input  sprite_pkg::mem_address_t mem_address,
	input  sprite_pkg::color_t       mem_data,
	input  logic                     read_enable,
	input  sprite_pkg::mem_address_t read_address,
	output sprite_pkg::color_t       read_data
);

	sprite_pkg::color_t mem [`MEM_DEPTH]; // images from word 0, background on top.

	// host side, only used while the screen is blank.
	always_ff @(posedge clk) begin
		if (mem_write) mem[mem_address] <= mem_data;
	end

	// display side, data appears one cycle after read_enable.
	always_ff @(posedge clk) begin
		if (read_enable) read_data <= mem[read_address];
	end

endmodule

// File: hdl/sprite_line_counter.sv
//////////////////////////////////////////////////
// sprite line counter: turns the pixel position
// inside a sprite into a pixel memory address.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "gpu_defines.svh"

module sprite_line_counter (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     sprite_on,
	input  sprite_pkg::sprite_word_t sprite_datas,
	input  video_pkg::check_value_t  check_value,
	output sprite_pkg::mem_address_t sprite_address,
	output logic                     count_finished
);

	localparam int OFFSET_BITS = $clog2(`SPRITE_SIZE);
	localparam int IMAGE_WORDS = `SPRITE_SIZE * `SPRITE_SIZE; // 400 words per image.

	logic                   sprite_on_q; // previous sprite_on, for edge detect.
	logic                   start;
	logic [OFFSET_BITS-1:0] row;         // line inside the sprite.
	logic [OFFSET_BITS-1:0] column;      // column inside the sprite.
	logic [4:0]             image;

	assign start = sprite_on && !sprite_on_q; // one pulse per sprite pixel.

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			sprite_on_q    <= 1'b0;
			count_finished <= 1'b0;
		end else begin
			sprite_on_q    <= sprite_on;
			count_finished <= start; // address is ready the cycle after the start.
		end
	end

	// first cycle: offsets from the sprite corner. the bank has already
	// checked the hit, so the differences always fit in 5 bits.
	always_ff @(posedge clk) begin
		if (start) begin
			row    <= OFFSET_BITS'(check_value.y - sprite_datas.y);
			column <= OFFSET_BITS'(check_value.x - sprite_datas.x);
			image  <= sprite_datas.image;
		end
	end

	// second cycle: image base plus row times the side plus column.
	assign sprite_address = sprite_pkg::mem_address_t'(14'(image) * 14'(IMAGE_WORDS) +
	                                                  14'(row) * 14'(`SPRITE_SIZE) +
	                                                  14'(column));

endmodule

// File: hdl/print_controller.sv
//////////////////////////////////////////////////
// print controller: walks each visible pixel
// through the background or sprite path, reads
// pixel memory and strobes the colour out.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "gpu_defines.svh"

module print_controller (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     pixel_tick,
	input  logic                     active_area,
	input  video_pkg::coord_x_t      pixel_x,
	input  video_pkg::coord_y_t      pixel_y,
	input  sprite_pkg::sprite_word_t data_reg,
	input  sprite_pkg::mem_address_t sprite_address,
	input  logic                     count_finished,
	input  sprite_pkg::color_t       read_data,
	output video_pkg::check_value_t  check_value,
	output logic                     sprite_on,
	output sprite_pkg::sprite_word_t sprite_datas,
	output sprite_pkg::mem_address_t read_address,
	output logic                     read_enable,
	output sprite_pkg::color_t       color,
	output logic                     color_valid
);

	sprite_pkg::print_state_t state;
	logic                     read_pending; // read_data is valid this cycle.
	logic                     is_background;

	assign is_background = (data_reg == sprite_pkg::sprite_word_t'(`BG_CODE));

	//////////////////////////////////////////////////
	// state walk and control flags
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state        <= sprite_pkg::RECEIVE;
			sprite_on    <= 1'b0;
			read_pending <= 1'b0;
			color_valid  <= 1'b0;
		end else begin
			read_pending <= read_enable;  // memory answers one cycle after the read.
			color_valid  <= read_pending; // strobe goes with the registered colour.
			case (state)
				sprite_pkg::RECEIVE: begin
					if (pixel_tick && active_area) state <= sprite_pkg::PROCESS;
				end
				sprite_pkg::PROCESS: begin
					if (is_background) begin
						state <= sprite_pkg::WAIT; // pad to the same length as a sprite.
					end else begin
						state     <= sprite_pkg::SPRITE;
						sprite_on <= 1'b1; // start the line counter.
					end
				end
				sprite_pkg::SPRITE: begin
					if (count_finished) begin
						state     <= sprite_pkg::RECEIVE;
						sprite_on <= 1'b0;
					end
				end
				sprite_pkg::WAIT:   state <= sprite_pkg::WAIT_2;
				sprite_pkg::WAIT_2: state <= sprite_pkg::RECEIVE;
				default:            state <= sprite_pkg::RECEIVE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// payload registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (state == sprite_pkg::RECEIVE && pixel_tick && active_area) begin
			check_value.x <= pixel_x; // held until the next pixel tick.
			check_value.y <= pixel_y;
		end
		if (state == sprite_pkg::PROCESS && !is_background) begin
			sprite_datas <= data_reg; // winning sprite for the line counter.
		end
		if (read_pending) color <= read_data;
	end

	// both paths read in the fourth cycle of the pixel, so strobes stay 4 apart.
	assign read_enable = (state == sprite_pkg::WAIT_2) ||
	                     (state == sprite_pkg::SPRITE && count_finished);
	assign read_address = (state == sprite_pkg::SPRITE) ? sprite_address
	                                                    : sprite_pkg::mem_address_t'(`BG_ADDRESS);

endmodule

// File: hdl/sprite_register_bank.sv
//////////////////////////////////////////////////
// sprite register bank: host writable sprite
// words and a priority hit test for one pixel.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "gpu_defines.svh"

module sprite_register_bank (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                reg_write,
	input  logic [$clog2(`SPRITE_COUNT)-1:0]    reg_index,
	input  sprite_pkg::sprite_word_t            reg_data,
	input  video_pkg::check_value_t             check_value,
	output sprite_pkg::sprite_word_t            data_reg
);

	sprite_pkg::sprite_word_t regs [`SPRITE_COUNT]; // one word per sprite.

	// true when coord lies in origin up to origin plus 19.
	// the sum is one bit wider so a sprite at the right edge does not wrap.
	function automatic logic in_span(input logic [9:0] coord, input logic [9:0] origin);
		logic [10:0] span_end;
		span_end = {1'b0, origin} + 11'(`SPRITE_SIZE);
		return ({1'b0, coord} >= {1'b0, origin}) && ({1'b0, coord} < span_end);
	endfunction

	//////////////////////////////////////////////////
	// host write port
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < `SPRITE_COUNT; i++) begin
				regs[i] <= '0; // valid bit cleared, every sprite hidden.
			end
		end else if (reg_write) begin
			regs[reg_index] <= reg_data; // takes effect on this edge.
		end
	end

	//////////////////////////////////////////////////
	// hit test
	//////////////////////////////////////////////////
	// the loop runs from the highest index down, so the last hit that
	// sticks is the lowest index and that sprite is drawn on top.
	always_comb begin
		data_reg = sprite_pkg::sprite_word_t'(`BG_CODE); // nothing covers the pixel.
		for (int i = `SPRITE_COUNT - 1; i >= 0; i--) begin
			if (regs[i].valid &&
			    in_span(check_value.x, regs[i].x) &&
			    in_span(check_value.y, regs[i].y)) begin
				data_reg = regs[i];
			end
		end
	end

endmodule

// File: hdl/video_timing.sv
//////////////////////////////////////////////////
// raster walker: pixel tick, line and frame
// counters, syncs and visible area flags.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "gpu_defines.svh"

module video_timing (
	input  logic                clk,
	input  logic                reset,
	output logic                pixel_tick,
	output logic                active_area,
	output video_pkg::coord_x_t pixel_x,
	output video_pkg::coord_y_t pixel_y,
	output logic                hsync,
	output logic                vsync,
	output logic                printing_screen
);

	localparam int PHASE_BITS = $clog2(`PIXEL_CYCLES);

	logic [PHASE_BITS-1:0] phase;   // position inside the current pixel.
	logic [9:0]            h_count; // column, 0 to 799.
	logic [9:0]            v_count; // line, 0 to 524.

	// the tick marks the last clk of a pixel, so the counters move right after it.
	assign pixel_tick = (phase == PHASE_BITS'(`PIXEL_CYCLES - 1));

	//////////////////////////////////////////////////
	// counters
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			phase   <= '0;
			h_count <= '0;
			v_count <= 10'(`SCREEN_Y); // start of vertical blanking, room for loading.
		end else begin
			if (pixel_tick) begin
				phase <= '0;
			end else begin
				phase <= phase + 1'b1;
			end
			if (pixel_tick) begin
				if (h_count == 10'(`H_TOTAL - 1)) begin
					h_count <= '0; // end of line.
					if (v_count == 10'(`V_TOTAL - 1)) begin
						v_count <= '0; // end of frame.
					end else begin
						v_count <= v_count + 1'b1;
					end
				end else begin
					h_count <= h_count + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// decoded outputs
	//////////////////////////////////////////////////
	assign pixel_x = h_count;
	assign pixel_y = v_count;

	// both counters inside the visible window.
	assign active_area = (h_count < 10'(`SCREEN_X)) && (v_count < 10'(`SCREEN_Y));
	assign printing_screen = active_area; // hosts may write while this is low.

	// syncs are active low inside their windows.
	assign hsync = !((h_count >= 10'(`H_SYNC_START)) && (h_count < 10'(`H_SYNC_END)));
	assign vsync = !((v_count >= 10'(`V_SYNC_START)) && (v_count < 10'(`V_SYNC_END)));

endmodule

// File: hdl/sprite_pkg.sv
//////////////////////////////////////////////////
// sprite types: register word layout, memory
// address, colour and print controller states.
//////////////////////////////////////////////////
package sprite_pkg;

	// one sprite register.
	// an image starts at image times 400 in pixel memory.
	typedef struct packed {
		logic                valid;  // sprite is drawn when set.
		logic [4:0]          image;  // image number in pixel memory.
		logic [5:0]          unused; // spare bits, ignored by the bank.
		video_pkg::coord_x_t x;      // left column of the square.
		video_pkg::coord_y_t y;      // top line of the square.
	} sprite_word_t;

	// pixel memory address, 16384 words.
	typedef logic [13:0] mem_address_t;

	// 3 bits each of red, green and blue.
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [2:0] blue;
	} color_t;

	// per-pixel walk of the print controller.
	typedef enum logic [2:0] {
		RECEIVE = 3'd0, // wait for a visible pixel tick.
		PROCESS = 3'd1, // bank answer is valid, pick a path.
		SPRITE  = 3'd2, // line counter forms the sprite address.
		WAIT    = 3'd3, // background path padding.
		WAIT_2  = 3'd4  // background read goes out here.
	} print_state_t;

endpackage

// File: hdl/video_pkg.sv
//////////////////////////////////////////////////
// raster types shared by the timing generator,
// the print controller and the sprite bank.
//////////////////////////////////////////////////
package video_pkg;

	// screen coordinates, wide enough for the whole 800x525 raster.
	typedef logic [9:0] coord_x_t;
	typedef logic [9:0] coord_y_t;

	// coordinate pair sent to the sprite bank for comparison.
	// x sits in the upper ten bits and y in the lower ten.
	typedef struct packed {
		coord_x_t x; // column of the pixel.
		coord_y_t y; // line of the pixel.
	} check_value_t;

	// the pair always packs into 20 bits.
	localparam int unsigned CHECK_VALUE_BITS = $bits(check_value_t);

endpackage

// File: hdl/gpu_defines.svh
//////////////////////////////////////////////////
// sprite engine constants: raster geometry, sync
// placement, sprite bank size and pixel memory map.
//////////////////////////////////////////////////
`ifndef GPU_DEFINES_SVH
`define GPU_DEFINES_SVH

// visible area and full raster of the 640x480 mode.
`define SCREEN_X      640
`define SCREEN_Y      480
`define H_TOTAL       800
`define V_TOTAL       525
`define H_SYNC_START  656 // front porch is 16 pixels.
`define H_SYNC_END    752 // sync pulse is 96 pixels wide.
`define V_SYNC_START  490 // front porch is 10 lines.
`define V_SYNC_END    492 // sync pulse is 2 lines high.
`define PIXEL_CYCLES  4   // clk cycles for every pixel.

// sprites and pixel memory.
`define SPRITE_COUNT  8
`define SPRITE_SIZE   20
`define MEM_DEPTH     16384
`define BG_ADDRESS    16383 // last word keeps the background colour.
`define BG_CODE       1     // bank answer when no sprite covers the pixel.

`endif
